// File: build.f
+incdir+hdl
hdl/rx_pkg.sv
hdl/rx_xfer_if.sv
hdl/adc_ovfl_detect.sv
hdl/rx_sample_latch.sv
hdl/rx_xfer_fsm.sv
hdl/rx_buffer.sv
hdl/receiver_top.sv
sim/tb_receiver.sv

// File: hdl/adc_ovfl_detect.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module adc_ovfl_detect
(
	input  logic                          adc_clk,
	input  logic                          reset_bufs_A,
	input  logic                          adc_ovfl_i,
	input  logic                          set_cnt_mask_i,
	input  logic [`ADC_OVFL_CTR_BITS-1:0] cnt_mask_i,
	output logic                          adc_ovfl_o
);

	localparam int CW = `ADC_OVFL_CTR_BITS;

	logic [CW-1:0] win_ctr;		// free running window position
	logic [CW-1:0] ovfl_cnt;	// overflow cycles seen in this window
	logic [CW-1:0] cnt_mask;
	logic          ovfl_q;

	wire win_end = &win_ctr;	// last cycle of the window

	// mask loads only on command
	always_ff @(posedge adc_clk)
	begin
		if (set_cnt_mask_i)
			cnt_mask <= cnt_mask_i;
	end

	////////////////////////////////////////////////////////////
	// window and overflow counting
	////////////////////////////////////////////////////////////

	// the window's last cycle is not counted, so the count cannot wrap
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			win_ctr  <= '0;
			ovfl_cnt <= '0;
			ovfl_q   <= 1'b0;
		end
		else if (win_end)
		begin
			ovfl_q   <= |(ovfl_cnt & cnt_mask);	// one cycle pulse after window end
			ovfl_cnt <= '0;
			win_ctr  <= '0;
		end
		else
		begin
			ovfl_q   <= 1'b0;
			ovfl_cnt <= ovfl_cnt + {{(CW-1){1'b0}}, adc_ovfl_i};
			win_ctr  <= win_ctr + 1'b1;
		end
	end

	assign adc_ovfl_o = ovfl_q;

endmodule

// File: hdl/receiver_top.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module receiver_top
(
	input  logic                          adc_clk,
	input  logic                          reset_bufs_A,
	input  logic                          adc_ovfl_i,
	input  logic                          set_cnt_mask_i,
	input  logic                          set_nsamps_i,
	input  logic [15:0]                   tos_i,
	input  logic                          rx_avail_i,
	input  logic [`RX_CHANS*48-1:0]       rx_iq_i,
	input  logic [47:0]                   ticks_i,
	input  logic                          get_rx_samp_i,
	input  logic                          get_buf_ctr_i,
	input  logic                          get_rx_srq_i,
	output logic                          rx_rd_o,
	output logic [`RX_WORD_BITS-1:0]      rx_dout_o,
	output logic                          srq_o,
	output logic                          adc_ovfl_o
);
	import rx_pkg::*;

	rx_word_t din;		// latch to buffer
	rx_word_t dout;		// buffer read port
	rx_word_t buf_ctr;
	logic     wr;

	rx_xfer_if xfer ();

	////////////////////////////////////////////////////////////
	// ADC overflow
	////////////////////////////////////////////////////////////

	adc_ovfl_detect i_ovfl
	(
		.adc_clk        (adc_clk),
		.reset_bufs_A   (reset_bufs_A),
		.adc_ovfl_i     (adc_ovfl_i),
		.set_cnt_mask_i (set_cnt_mask_i),
		.cnt_mask_i     (tos_i[`ADC_OVFL_CTR_BITS-1:0]),
		.adc_ovfl_o     (adc_ovfl_o)
	);

	////////////////////////////////////////////////////////////
	// audio sample path
	////////////////////////////////////////////////////////////

	rx_sample_latch i_latch
	(
		.adc_clk    (adc_clk),
		.rx_avail_i (rx_avail_i),
		.rx_iq_i    (rx_iq_i),		// flat bus as packed records
		.ticks_i    (ticks_i),
		.xfer       (xfer.latch),
		.din_o      (din)
	);

	rx_xfer_fsm i_fsm
	(
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.rx_avail_i   (rx_avail_i),
		.set_nsamps_i (set_nsamps_i),
		.nsamps_i     (tos_i[7:0]),
		.get_rx_srq_i (get_rx_srq_i),
		.xfer         (xfer.fsm),
		.wr_o         (wr),
		.buf_ctr_o    (buf_ctr),
		.srq_o        (srq_o)
	);

	rx_buffer i_buf
	(
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.wr_i         (wr),
		.din_i        (din),
		.rd_i         (get_rx_samp_i),
		.dout_o       (dout)
	);

	assign rx_rd_o   = get_rx_samp_i | get_buf_ctr_i;
	assign rx_dout_o = get_buf_ctr_i ? buf_ctr : dout;	// count bypasses the buffer

endmodule

// File: hdl/rx_buffer.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module rx_buffer
(
	input  logic             adc_clk,
	input  logic             reset_bufs_A,
	input  logic             wr_i,
	input  rx_pkg::rx_word_t din_i,
	input  logic             rd_i,
	output rx_pkg::rx_word_t dout_o
);
	import rx_pkg::*;

	localparam int DEPTH = 1 << `RXBUF_ADDR_BITS;

	rx_word_t                    mem [DEPTH];
	logic [`RXBUF_ADDR_BITS-1:0] waddr;
	logic [`RXBUF_ADDR_BITS-1:0] raddr;
	rx_word_t                    dout_q;

	// both addresses just wrap, a slow reader loses old data
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			waddr <= '0;
		else if (wr_i)
			waddr <= waddr + 1'b1;
	end

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			raddr <= '0;
		else if (rd_i)
			raddr <= raddr + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// memory
	////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (wr_i)
			mem[waddr] <= din_i;
		dout_q <= mem[raddr];	// follows raddr one cycle late
	end

	assign dout_o = dout_q;

endmodule

// File: hdl/rx_config.svh
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// receiver channels interleaved into the audio buffer
`define RX_CHANS 4

// buffer holds 2**RXBUF_ADDR_BITS words
`define RXBUF_ADDR_BITS 10

// width of one buffer word
`define RX_WORD_BITS 16

// overflow window is 2**ADC_OVFL_CTR_BITS adc_clk cycles
// and the overflow mask has the same width
`define ADC_OVFL_CTR_BITS 16

`endif

// File: hdl/rx_pkg.sv
`include "rx_config.svh"

package rx_pkg;

	// width of a channel index
	localparam int RX_CH_BITS = (`RX_CHANS > 1) ? $clog2(`RX_CHANS) : 1;

	typedef logic [`RX_WORD_BITS-1:0] rx_word_t;	// one buffer word

	// one 48-bit sample record seen two ways
	typedef union packed
	{
		struct packed
		{
			rx_word_t iq3;	// word 2
			rx_word_t q;	// word 1
			rx_word_t i;	// word 0 sits in the low bits
		} f;
		rx_word_t [2:0] w;	// picked by word select when writing
	} rx_rec_u;

	typedef logic [1:0] word_sel_t;	// 0 = i / tick low, 1 = q / tick mid, 2 = iq3 / tick high

	// one extra bit so RX_CHANS itself can mark all channels moved
	typedef logic [RX_CH_BITS:0] chan_t;

endpackage

// File: hdl/rx_sample_latch.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module rx_sample_latch
(
	input  logic                             adc_clk,
	input  logic                             rx_avail_i,
	input  rx_pkg::rx_rec_u [`RX_CHANS-1:0]  rx_iq_i,
	input  rx_pkg::rx_rec_u                  ticks_i,
	rx_xfer_if.latch                         xfer,
	output rx_pkg::rx_word_t                 din_o
);
	import rx_pkg::*;

	rx_rec_u [`RX_CHANS-1:0] chan_q;	// samples held for the transfer
	rx_rec_u                 ticks_q;	// tick count at the strobe
	logic [RX_CH_BITS-1:0]   rxn_d;		// channel select one cycle late

	////////////////////////////////////////////////////////////
	// capture on the available strobe
	////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (rx_avail_i)
		begin
			for (int n = 0; n < `RX_CHANS; n++)
			begin
				chan_q[n].f.i   <= rx_iq_i[n].f.i;
				chan_q[n].f.q   <= rx_iq_i[n].f.q;
				chan_q[n].f.iq3 <= rx_iq_i[n].f.iq3;
			end
			ticks_q <= ticks_i;
		end
	end

	// the FSM bumps rxn together with the iq3 select, so the mux
	// must see the channel one cycle late to stay on the old one
	always_ff @(posedge adc_clk)
	begin
		rxn_d <= xfer.rxn[RX_CH_BITS-1:0];	// drops the all done bit
	end

	////////////////////////////////////////////////////////////
	// write data select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (xfer.use_ts)
			din_o = ticks_q.w[xfer.tsel];		// tick low, mid, high
		else if (xfer.use_ctr)
			din_o = xfer.buf_ctr;			// trailing count word
		else
			din_o = chan_q[rxn_d].w[xfer.tsel];	// i, q, iq3
	end

endmodule

// File: hdl/rx_xfer_fsm.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module rx_xfer_fsm
(
	input  logic             adc_clk,
	input  logic             reset_bufs_A,
	input  logic             rx_avail_i,
	input  logic             set_nsamps_i,
	input  logic [7:0]       nsamps_i,
	input  logic             get_rx_srq_i,
	rx_xfer_if.fsm           xfer,
	output logic             wr_o,
	output rx_pkg::rx_word_t buf_ctr_o,
	output logic             srq_o
);
	import rx_pkg::*;

	localparam chan_t ALL_DONE = chan_t'(`RX_CHANS);	// pseudo channel after the last one
	localparam chan_t LAST_CH  = chan_t'(`RX_CHANS - 1);

	logic       transfer;	// a sample set is being moved
	logic [7:0] count;	// sample sets moved into this buffer
	logic [1:0] move;	// i, q, iq3 step within a channel
	chan_t      rxn;
	word_sel_t  tsel;
	logic       use_ts;
	logic       use_ctr;
	logic       wr;
	logic [7:0] nrx_samps;	// sample sets per buffer
	logic [7:0] last_cnt;
	rx_word_t   buf_ctr;	// completed buffers
	logic       srq;

	// kept 8 bits wide so nrx_samps of 0 wraps the same way as count
	assign last_cnt = nrx_samps - 8'd1;

	always_ff @(posedge adc_clk)
	begin
		if (set_nsamps_i)
			nrx_samps <= nsamps_i;
	end

	////////////////////////////////////////////////////////////
	// transfer FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			transfer <= 1'b0;
			count    <= '0;
			move     <= '0;
			rxn      <= '0;
			tsel     <= '0;
			use_ts   <= 1'b0;
			use_ctr  <= 1'b0;
			wr       <= 1'b0;
			buf_ctr  <= '0;
			srq      <= 1'b0;
		end
		else
		begin
			if (rx_avail_i)
				transfer <= 1'b1;	// starts on the cycle after the strobe
			if (get_rx_srq_i)
				srq <= 1'b0;		// a completion in the same cycle still wins below
			if (transfer)
			begin
				if (rxn == ALL_DONE)
				begin
					if ((count == last_cnt) && !use_ts)
					begin
						// last set, carry on with three tick words
						move   <= 2'd1;
						wr     <= 1'b1;
						rxn    <= LAST_CH;	// one channel's worth of words
						use_ts <= 1'b1;
						tsel   <= 2'd0;
					end
					else if ((count == last_cnt) && use_ts)
					begin
						wr      <= 1'b1;
						count   <= count + 8'd1;	// only one count word goes out
						use_ts  <= 1'b0;
						use_ctr <= 1'b1;
					end
					else if (count == nrx_samps)
					begin
						// buffer complete
						transfer <= 1'b0;
						count    <= '0;
						move     <= '0;
						rxn      <= '0;
						tsel     <= '0;
						use_ctr  <= 1'b0;
						wr       <= 1'b0;
						buf_ctr  <= buf_ctr + 1'b1;
						srq      <= 1'b1;
					end
					else
					begin
						// set done, idle until the next strobe
						transfer <= 1'b0;
						count    <= count + 8'd1;
						move     <= '0;
						rxn      <= '0;
						wr       <= 1'b0;
					end
				end
				else
				begin
					case (move)
						2'd0:
						begin
							move <= 2'd1;
							tsel <= 2'd0;
						end
						2'd1:
						begin
							move <= 2'd2;
							tsel <= 2'd1;
						end
						2'd2:
						begin
							move <= 2'd0;
							tsel <= 2'd2;
							rxn  <= rxn + 1'b1;	// next channel
						end
						default:
						begin
							move <= 2'd0;
							tsel <= 2'd0;
						end
					endcase
					wr <= 1'b1;	// one word per cycle
				end
			end
			else
			begin
				move    <= '0;
				rxn     <= '0;
				tsel    <= '0;
				use_ts  <= 1'b0;
				use_ctr <= 1'b0;
				wr      <= 1'b0;
			end
		end
	end

	assign xfer.rxn     = rxn;
	assign xfer.tsel    = tsel;
	assign xfer.use_ts  = use_ts;
	assign xfer.use_ctr = use_ctr;
	assign xfer.buf_ctr = buf_ctr;
	assign wr_o         = wr;
	assign buf_ctr_o    = buf_ctr;
	assign srq_o        = srq;

endmodule

// File: hdl/rx_xfer_if.sv
`timescale 1ns/10ps

// word select controls from the transfer FSM to the sample latch
interface rx_xfer_if;
	import rx_pkg::*;

	chan_t     rxn;		// channel being moved
	word_sel_t tsel;	// word within channel or ticks
	logic      use_ts;	// pick a tick word
	logic      use_ctr;	// pick the buffer count word
	rx_word_t  buf_ctr;	// buffer count before increment

	modport fsm
	(
		output rxn,
		output tsel,
		output use_ts,
		output use_ctr,
		output buf_ctr
	);

	modport latch
	(
		input rxn,
		input tsel,
		input use_ts,
		input use_ctr,
		input buf_ctr
	);

endinterface

// File: sim/tb_receiver.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module tb_receiver;
	import rx_pkg::*;

	localparam int SET_GAP   = 40;			// cycles between sample sets
	localparam int SET_WORDS = `RX_CHANS * 3;	// i, q, iq3 per channel
	localparam int NSAMPS    = 3;			// sample sets per buffer
	localparam int OVFL_WIN  = 1 << `ADC_OVFL_CTR_BITS;
	localparam int GROUP_CYC = NSAMPS * SET_GAP + (NSAMPS * SET_WORDS + 4) * 4 + 100;
	localparam int WDOG_CYC  = 10 + 5 * GROUP_CYC + 2 * OVFL_WIN + 500;

	logic                      adc_clk;
	logic                      reset_bufs_A;
	logic                      adc_ovfl_i;
	logic                      set_cnt_mask_i;
	logic                      set_nsamps_i;
	logic [15:0]               tos_i;
	logic                      rx_avail_i;
	logic [`RX_CHANS*48-1:0]   rx_iq_i;
	logic [47:0]               ticks_i;
	logic                      get_rx_samp_i;
	logic                      get_buf_ctr_i;
	logic                      get_rx_srq_i;
	logic                      rx_rd_o;
	logic [`RX_WORD_BITS-1:0]  rx_dout_o;
	logic                      srq_o;
	logic                      adc_ovfl_o;

	rx_word_t model_q[$];	// expected buffer words in read order
	int       model_sets;	// sets seen in the current group
	rx_word_t model_bufs;	// completed buffers
	int       errors;
	int       checks;
	int       tests;

	receiver_top i_dut
	(
		.adc_clk        (adc_clk),
		.reset_bufs_A   (reset_bufs_A),
		.adc_ovfl_i     (adc_ovfl_i),
		.set_cnt_mask_i (set_cnt_mask_i),
		.set_nsamps_i   (set_nsamps_i),
		.tos_i          (tos_i),
		.rx_avail_i     (rx_avail_i),
		.rx_iq_i        (rx_iq_i),
		.ticks_i        (ticks_i),
		.get_rx_samp_i  (get_rx_samp_i),
		.get_buf_ctr_i  (get_buf_ctr_i),
		.get_rx_srq_i   (get_rx_srq_i),
		.rx_rd_o        (rx_rd_o),
		.rx_dout_o      (rx_dout_o),
		.srq_o          (srq_o),
		.adc_ovfl_o     (adc_ovfl_o)
	);

	initial
	begin
		adc_clk = 1'b0;
		forever #20 adc_clk = ~adc_clk;	// 40 ns period
	end

	// watchdog sized from the test lengths
	initial
	begin
		repeat (WDOG_CYC) @(posedge adc_clk);
		$display("watchdog expired after %0d cycles, the tests did not finish", WDOG_CYC);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input rx_word_t got, input rx_word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests++;
		if (errors == start)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: FAILED with %0d errors", tests, name, errors - start);
	endtask

	////////////////////////////////////////////////////////////
	// stimulus and model
	////////////////////////////////////////////////////////////

	task automatic set_nsamps(input int n);
		@(posedge adc_clk);
		tos_i        <= 16'(n);
		set_nsamps_i <= 1'b1;
		@(posedge adc_clk);
		set_nsamps_i <= 1'b0;
	endtask

	// one random sample set with its model words queued in buffer order
	task automatic send_set();
		logic [47:0] rec;
		logic [47:0] ticks;
		@(posedge adc_clk);
		for (int n = 0; n < `RX_CHANS; n++)
		begin
			rec = {16'($urandom), $urandom};
			rx_iq_i[n*48 +: 48] <= rec;
			model_q.push_back(rec[15:0]);	// i
			model_q.push_back(rec[31:16]);	// q
			model_q.push_back(rec[47:32]);	// iq3
		end
		ticks = {16'($urandom), $urandom};
		ticks_i    <= ticks;
		rx_avail_i <= 1'b1;
		model_sets++;
		if (model_sets == NSAMPS)
		begin
			model_q.push_back(ticks[15:0]);		// tick low
			model_q.push_back(ticks[31:16]);
			model_q.push_back(ticks[47:32]);	// tick high
			model_q.push_back(model_bufs);		// count before increment
			model_bufs = model_bufs + 1'b1;
			model_sets = 0;
		end
		@(posedge adc_clk);
		rx_avail_i <= 1'b0;
	endtask

	task automatic wait_srq();
		int n;
		n = 0;
		@(negedge adc_clk);
		while (srq_o !== 1'b1 && n < SET_GAP)
		begin
			@(negedge adc_clk);
			n++;
		end
		if (srq_o !== 1'b1)
		begin
			errors++;
			$display("srq_o did not rise within %0d cycles of the last sample set", SET_GAP);
		end
		else if (n < SET_WORDS + 4)
		begin
			errors++;
			$display("srq_o rose after %0d cycles, before the tick and count words", n);
		end
	endtask

	// full buffer group where srq_o stays low until the last set
	task automatic run_group();
		for (int s = 1; s <= NSAMPS; s++)
		begin
			send_set();
			if (s < NSAMPS)
			begin
				repeat (SET_GAP - 2) @(posedge adc_clk);	// next strobe SET_GAP cycles on
				@(negedge adc_clk);
				check_bit("srq_o", srq_o, 1'b0);
			end
			else
				wait_srq();
		end
	endtask

	task automatic drain_buffer();
		rx_word_t exp;
		while (model_q.size() > 0)
		begin
			exp = model_q.pop_front();
			@(negedge adc_clk);
			check_word("rx_dout_o", rx_dout_o, exp);
			check_bit("rx_rd_o", rx_rd_o, 1'b0);	// no read strobe yet
			@(posedge adc_clk);
			get_rx_samp_i <= 1'b1;
			@(negedge adc_clk);
			check_bit("rx_rd_o", rx_rd_o, 1'b1);
			@(posedge adc_clk);
			get_rx_samp_i <= 1'b0;
			@(posedge adc_clk);	// registered read catches up
		end
	endtask

	task automatic clear_srq();
		@(posedge adc_clk);
		get_rx_srq_i <= 1'b1;
		@(posedge adc_clk);
		get_rx_srq_i <= 1'b0;
		@(negedge adc_clk);
		check_bit("srq_o", srq_o, 1'b0);
	endtask

	// two full windows against a masked count model
	task automatic check_overflow();
		logic [`ADC_OVFL_CTR_BITS-1:0] mask;
		logic [`ADC_OVFL_CTR_BITS-1:0] cnt;
		logic                          exp;
		logic                          v;
		int                            rate;
		int                            pos;
		mask = `ADC_OVFL_CTR_BITS'($urandom);
		@(posedge adc_clk);
		tos_i          <= 16'(mask);
		set_cnt_mask_i <= 1'b1;
		@(posedge adc_clk);
		set_cnt_mask_i <= 1'b0;
		reset_bufs_A   <= 1'b1;	// window restarts here
		@(posedge adc_clk);
		reset_bufs_A <= 1'b0;
		cnt = '0;
		exp = 1'b0;
		for (int c = 1; c <= 2 * OVFL_WIN + 1; c++)
		begin
			pos  = (c - 1) % OVFL_WIN;			// window position at the next edge
			rate = (c <= OVFL_WIN) ? 2048 : 32768;		// second window is sparse
			v    = ($urandom % rate) == 0;
			adc_ovfl_i <= v;
			@(negedge adc_clk);
			check_bit("adc_ovfl_o", adc_ovfl_o, exp);
			if (pos == OVFL_WIN - 1)
			begin
				exp = |(cnt & mask);	// the window's last cycle is not counted
				cnt = '0;
			end
			else
			begin
				exp = 1'b0;
				cnt = cnt + v;
			end
			@(posedge adc_clk);
		end
		adc_ovfl_i <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int start;
		int seed_val;
		seed_val = $urandom(32'h76d1_8afd);	// one seed for the whole run
		errors = 0;
		checks = 0;
		tests  = 0;
		model_sets = 0;
		model_bufs = '0;
		reset_bufs_A   = 1'b1;
		adc_ovfl_i     = 1'b0;
		set_cnt_mask_i = 1'b0;
		set_nsamps_i   = 1'b0;
		tos_i          = '0;
		rx_avail_i     = 1'b0;
		rx_iq_i        = '0;
		ticks_i        = '0;
		get_rx_samp_i  = 1'b0;
		get_buf_ctr_i  = 1'b0;
		get_rx_srq_i   = 1'b0;
		repeat (10) @(posedge adc_clk);
		reset_bufs_A <= 1'b0;
		set_nsamps(NSAMPS);

		start = errors;
		run_group();
		drain_buffer();
		clear_srq();
		report_test("first buffer, count word 0", start);

		start = errors;
		run_group();
		drain_buffer();
		@(posedge adc_clk);
		get_buf_ctr_i <= 1'b1;
		@(negedge adc_clk);
		check_word("rx_dout_o", rx_dout_o, model_bufs);	// reads the counter and not the buffer
		check_bit("rx_rd_o", rx_rd_o, 1'b1);
		@(posedge adc_clk);
		get_buf_ctr_i <= 1'b0;
		clear_srq();
		report_test("second buffer and counter read", start);

		start = errors;
		run_group();
		drain_buffer();
		@(negedge adc_clk);
		check_bit("srq_o", srq_o, 1'b1);	// still pending after the reads
		clear_srq();
		report_test("service request", start);

		start = errors;
		send_set();
		repeat (SET_GAP - 2) @(posedge adc_clk);
		send_set();
		repeat (6) @(posedge adc_clk);		// lands inside the transfer
		reset_bufs_A <= 1'b1;
		repeat (3) @(posedge adc_clk);
		reset_bufs_A <= 1'b0;
		model_q.delete();
		model_sets = 0;
		model_bufs = '0;
		@(negedge adc_clk);
		check_bit("srq_o", srq_o, 1'b0);
		run_group();
		drain_buffer();
		clear_srq();
		report_test("reset inside a group", start);

		start = errors;
		check_overflow();
		report_test("overflow windows", start);

		$display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
